/* verilog/fabric_pkg.sv */
package fabric_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    localparam int NUM_REGIONS = 3;

    typedef logic [1:0] region_idx_t;

    localparam region_idx_t UART_IDX  = 2'd0;
    localparam region_idx_t TIMER_IDX = 2'd1;
    localparam region_idx_t MEM_IDX   = 2'd2;

    // Address map, indexed by region
    localparam logic [ADDR_W-1:0] REGION_BASE [NUM_REGIONS] = '{
        32'h4000_0000,
        32'h4001_0000,
        32'h8000_0000
    };

    // Inclusive upper bounds
    localparam logic [ADDR_W-1:0] REGION_END [NUM_REGIONS] = '{
        32'h4000_1FFF,
        32'h4001_00FF,
        32'h8FFF_FFFF
    };

    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
    } bus_req_t;

    typedef struct packed {
        logic              valid;
        logic              err;
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

    // Timer register offsets, relative to the timer base
    localparam logic [ADDR_W-1:0] TIMER_MTIME_LO = 32'h0;
    localparam logic [ADDR_W-1:0] TIMER_MTIME_HI = 32'h4;
    localparam logic [ADDR_W-1:0] TIMER_CMP_LO   = 32'h8;
    localparam logic [ADDR_W-1:0] TIMER_CMP_HI   = 32'hC;

endpackage

/* verilog/addr_decoder.sv */
module addr_decoder (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  fabric_pkg::bus_req_t core_req_i,
    output logic                 core_ready_o,
    input  logic                 core_rsp_valid_i,
    output fabric_pkg::bus_req_t slot_req_o [fabric_pkg::NUM_REGIONS],
    output logic                 dec_err_o
);

    import fabric_pkg::*;

    logic        busy_q;
    logic        accept;
    logic        hit_any;
    region_idx_t hit_idx;

    assign core_ready_o = ~busy_q;
    assign accept       = core_req_i.valid & ~busy_q;

    // Regions do not overlap, so at most one can hit
    always_comb begin
        hit_any = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < NUM_REGIONS; i++) begin
            if (core_req_i.addr >= REGION_BASE[i] && core_req_i.addr <= REGION_END[i]) begin
                hit_any = 1'b1;
                hit_idx = region_idx_t'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_REGIONS; i++) begin
            slot_req_o[i]       = core_req_i;
            slot_req_o[i].valid = accept & hit_any & (hit_idx == region_idx_t'(i));
        end
    end

    assign dec_err_o = accept & ~hit_any;

    // One access in flight, ended by the merged response
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end else if (core_rsp_valid_i) begin
            busy_q <= 1'b0;
        end
    end

endmodule

/* verilog/region_slice.sv */
module region_slice (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  fabric_pkg::bus_req_t          slot_req_i,
    input  logic [fabric_pkg::ADDR_W-1:0] base_i,
    output fabric_pkg::bus_rsp_t          slot_rsp_o,
    output fabric_pkg::bus_req_t          periph_req_o,
    input  logic                          periph_ready_i,
    input  fabric_pkg::bus_rsp_t          periph_rsp_i
);

    import fabric_pkg::*;

    logic              valid_q;
    logic              wait_q;
    logic              write_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [STRB_W-1:0] wstrb_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            wait_q  <= 1'b0;
        end else begin
            if (slot_req_i.valid) begin
                valid_q <= 1'b1;
            end else if (valid_q && periph_ready_i) begin
                valid_q <= 1'b0;
                wait_q  <= 1'b1;
            end
            if (wait_q && periph_rsp_i.valid) begin
                wait_q <= 1'b0;
            end
        end
    end

    // Payload, rebased into the region
    always_ff @(posedge clk_i) begin
        if (slot_req_i.valid) begin
            write_q <= slot_req_i.write;
            addr_q  <= slot_req_i.addr - base_i;
            wdata_q <= slot_req_i.wdata;
            wstrb_q <= slot_req_i.wstrb;
        end
    end

    assign periph_req_o = '{
        valid: valid_q,
        write: write_q,
        addr:  addr_q,
        wdata: wdata_q,
        wstrb: wstrb_q
    };

    // Only a response to our own access goes back
    always_comb begin
        slot_rsp_o       = periph_rsp_i;
        slot_rsp_o.valid = periph_rsp_i.valid & wait_q;
    end

endmodule

/* verilog/resp_merger.sv */
module resp_merger (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  fabric_pkg::bus_rsp_t slot_rsp_i [fabric_pkg::NUM_REGIONS],
    input  logic                 dec_err_i,
    output fabric_pkg::bus_rsp_t core_rsp_o
);

    import fabric_pkg::*;

    logic              any_valid;
    logic              err_d;
    logic [DATA_W-1:0] rdata_d;
    logic              valid_q;
    logic              err_q;
    logic [DATA_W-1:0] rdata_q;

    // Sources are exclusive, so an OR of the gated payloads is enough
    always_comb begin
        any_valid = dec_err_i;
        err_d     = dec_err_i;
        rdata_d   = '0;
        for (int i = 0; i < NUM_REGIONS; i++) begin
            if (slot_rsp_i[i].valid) begin
                any_valid = 1'b1;
                err_d     = err_d | slot_rsp_i[i].err;
                rdata_d   = rdata_d | slot_rsp_i[i].rdata;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= any_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (any_valid) begin
            err_q   <= err_d;
            rdata_q <= rdata_d;
        end
    end

    assign core_rsp_o = '{valid: valid_q, err: err_q, rdata: rdata_q};

endmodule

/* verilog/mtimer.sv */
module mtimer (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  fabric_pkg::bus_req_t req_i,
    output logic                 ready_o,
    output fabric_pkg::bus_rsp_t rsp_o,
    output logic [63:0]          time_o,
    output logic                 irq_o
);

    import fabric_pkg::*;

    logic [63:0]       mtime_q;
    logic [63:0]       mtime_d;
    logic [63:0]       cmp_q;
    logic [63:0]       cmp_d;
    logic              irq_q;
    logic              hit;
    logic [DATA_W-1:0] rd_data;
    logic              rsp_valid_q;
    logic              rsp_err_q;
    logic [DATA_W-1:0] rsp_rdata_q;

    assign ready_o = 1'b1;
    assign mtime_d = mtime_q + 64'd1;

    always_comb begin
        hit     = 1'b1;
        rd_data = '0;
        case (req_i.addr)
            TIMER_MTIME_LO: rd_data = mtime_q[31:0];
            TIMER_MTIME_HI: rd_data = mtime_q[63:32];
            TIMER_CMP_LO:   rd_data = cmp_q[31:0];
            TIMER_CMP_HI:   rd_data = cmp_q[63:32];
            default:        hit = 1'b0;
        endcase
    end

    // Byte-wise compare update, mtime is read only
    always_comb begin
        cmp_d = cmp_q;
        if (req_i.valid && req_i.write) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (req_i.wstrb[b]) begin
                    if (req_i.addr == TIMER_CMP_LO) begin
                        cmp_d[b*8 +: 8] = req_i.wdata[b*8 +: 8];
                    end else if (req_i.addr == TIMER_CMP_HI) begin
                        cmp_d[32 + b*8 +: 8] = req_i.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtime_q     <= '0;
            cmp_q       <= '1;
            irq_q       <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            mtime_q     <= mtime_d;
            cmp_q       <= cmp_d;
            // Uses next values so irq tracks time_o without lag
            irq_q       <= (mtime_d >= cmp_d);
            rsp_valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            rsp_err_q   <= ~hit;
            rsp_rdata_q <= req_i.write ? '0 : rd_data;
        end
    end

    assign rsp_o  = '{valid: rsp_valid_q, err: rsp_err_q, rdata: rsp_rdata_q};
    assign time_o = mtime_q;
    assign irq_o  = irq_q;

endmodule

/* verilog/periph_fabric.sv */
module periph_fabric (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Core port
    input  fabric_pkg::bus_req_t core_req_i,
    output logic                 core_ready_o,
    output fabric_pkg::bus_rsp_t core_rsp_o,

    // Memory port
    output fabric_pkg::bus_req_t mem_req_o,
    input  logic                 mem_ready_i,
    input  fabric_pkg::bus_rsp_t mem_rsp_i,

    // UART port
    output fabric_pkg::bus_req_t uart_req_o,
    input  logic                 uart_ready_i,
    input  fabric_pkg::bus_rsp_t uart_rsp_i,

    output logic [63:0]          time_o,
    output logic                 timer_irq_o
);

    import fabric_pkg::*;

    bus_req_t slot_req     [NUM_REGIONS];
    bus_rsp_t slot_rsp     [NUM_REGIONS];
    bus_req_t periph_req   [NUM_REGIONS];
    logic     periph_ready [NUM_REGIONS];
    bus_rsp_t periph_rsp   [NUM_REGIONS];
    logic     dec_err;

    addr_decoder decoder_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .core_req_i       (core_req_i),
        .core_ready_o     (core_ready_o),
        .core_rsp_valid_i (core_rsp_o.valid),
        .slot_req_o       (slot_req),
        .dec_err_o        (dec_err)
    );

    for (genvar g = 0; g < NUM_REGIONS; g++) begin : g_slice
        region_slice slice_i (
            .clk_i          (clk_i),
            .rst_n_i        (rst_n_i),
            .slot_req_i     (slot_req[g]),
            .base_i         (REGION_BASE[g]),
            .slot_rsp_o     (slot_rsp[g]),
            .periph_req_o   (periph_req[g]),
            .periph_ready_i (periph_ready[g]),
            .periph_rsp_i   (periph_rsp[g])
        );
    end

    resp_merger merger_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .slot_rsp_i (slot_rsp),
        .dec_err_i  (dec_err),
        .core_rsp_o (core_rsp_o)
    );

    mtimer timer_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (periph_req[TIMER_IDX]),
        .ready_o (periph_ready[TIMER_IDX]),
        .rsp_o   (periph_rsp[TIMER_IDX]),
        .time_o  (time_o),
        .irq_o   (timer_irq_o)
    );

    // External regions
    assign mem_req_o              = periph_req[MEM_IDX];
    assign periph_ready[MEM_IDX]  = mem_ready_i;
    assign periph_rsp[MEM_IDX]    = mem_rsp_i;

    assign uart_req_o             = periph_req[UART_IDX];
    assign periph_ready[UART_IDX] = uart_ready_i;
    assign periph_rsp[UART_IDX]   = uart_rsp_i;

endmodule

/* dv/periph_fabric_sva.sv */
module periph_fabric_sva (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input fabric_pkg::bus_req_t core_req_i,
    input logic                 core_ready_o,
    input fabric_pkg::bus_rsp_t core_rsp_o,
    input fabric_pkg::bus_req_t mem_req_o,
    input logic                 mem_ready_i,
    input fabric_pkg::bus_req_t uart_req_o,
    input logic                 uart_ready_i
);

    // Held requests keep their fields until taken
    mem_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o.valid && !mem_ready_i |=> $stable(mem_req_o))
        else $error("memory request changed while waiting for ready");

    uart_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        uart_req_o.valid && !uart_ready_i |=> $stable(uart_req_o))
        else $error("UART request changed while waiting for ready");

    rsp_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_rsp_o.valid |=> !core_rsp_o.valid)
        else $error("core response valid longer than one cycle");

    busy_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_req_i.valid && core_ready_o |=> !core_ready_o)
        else $error("core ready high right after acceptance");

    busy_until_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !core_ready_o && !core_rsp_o.valid |=> !core_ready_o)
        else $error("core ready rose before the response");

    one_external: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({mem_req_o.valid, uart_req_o.valid}))
        else $error("more than one external request valid");

endmodule

bind periph_fabric periph_fabric_sva sva_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .core_req_i   (core_req_i),
    .core_ready_o (core_ready_o),
    .core_rsp_o   (core_rsp_o),
    .mem_req_o    (mem_req_o),
    .mem_ready_i  (mem_ready_i),
    .uart_req_o   (uart_req_o),
    .uart_ready_i (uart_ready_i)
);

/* dv/periph_fabric_tb.sv */
module periph_fabric_tb;

    import fabric_pkg::*;

    localparam int          NUM_TXN      = 90;
    localparam logic [31:0] UART_PATTERN = 32'h5A5A_C3C3;

    logic        clk_i = 1'b0;
    logic        rst_n_i = 1'b0;
    bus_req_t    core_req_i = '0;
    logic        core_ready_o;
    bus_rsp_t    core_rsp_o;
    bus_req_t    mem_req_o;
    logic        mem_ready_i = 1'b0;
    bus_rsp_t    mem_rsp_i = '0;
    bus_req_t    uart_req_o;
    logic        uart_ready_i = 1'b0;
    bus_rsp_t    uart_rsp_i = '0;
    logic [63:0] time_o;
    logic        timer_irq_o;

    integer      seed = 96081;
    int          cyc = 0;
    int          issued = 0;
    int          rsp_seen = 0;
    bus_req_t    last_req = '0;
    bus_rsp_t    exp_q [$];
    int          acc_q [$];
    int          lat_q [$];
    logic [31:0] mem_shadow [logic [31:0]];
    logic [31:0] mem_model [logic [31:0]];
    logic [63:0] cmp_shadow = '1;
    logic [31:0] uart_log [$];

    periph_fabric dut_i (.*);

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic tick();
        @(posedge clk_i);
        #2;
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[b*8 +: 8] = nw[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic int find_region(input logic [31:0] addr);
        for (int i = 0; i < NUM_REGIONS; i++) begin
            if (addr >= REGION_BASE[i] && addr <= REGION_END[i]) return i;
        end
        return -1;
    endfunction

    // Expected response from the map and the shadow state
    function automatic bus_rsp_t expect_rsp(input bus_req_t req, input logic [63:0] t_now);
        bus_rsp_t    rsp;
        int          region;
        logic [31:0] off;
        logic [63:0] t_acc;
        rsp    = '{valid: 1'b1, err: 1'b0, rdata: '0};
        region = find_region(req.addr);
        t_acc  = t_now + 64'd1;
        if (region < 0) begin
            rsp.err = 1'b1;
            return rsp;
        end
        off = req.addr - REGION_BASE[region];
        if (region == TIMER_IDX) begin
            case (off)
                TIMER_MTIME_LO: rsp.rdata = t_acc[31:0];
                TIMER_MTIME_HI: rsp.rdata = t_acc[63:32];
                TIMER_CMP_LO:   rsp.rdata = cmp_shadow[31:0];
                TIMER_CMP_HI:   rsp.rdata = cmp_shadow[63:32];
                default:        rsp.err = 1'b1;
            endcase
        end else if (region == MEM_IDX) begin
            rsp.rdata = mem_shadow.exists(off) ? mem_shadow[off] : '0;
        end else begin
            rsp.rdata = UART_PATTERN;
        end
        if (req.write) rsp.rdata = '0;
        return rsp;
    endfunction

    function automatic void update_shadow(input bus_req_t req);
        logic [31:0] off;
        int          region;
        region = find_region(req.addr);
        if (!req.write || region < 0) return;
        off = req.addr - REGION_BASE[region];
        if (region == MEM_IDX) begin
            mem_shadow[off] = merge_bytes(mem_shadow.exists(off) ? mem_shadow[off] : '0,
                                          req.wdata, req.wstrb);
        end else if (region == TIMER_IDX && off == TIMER_CMP_LO) begin
            cmp_shadow[31:0] = merge_bytes(cmp_shadow[31:0], req.wdata, req.wstrb);
        end else if (region == TIMER_IDX && off == TIMER_CMP_HI) begin
            cmp_shadow[63:32] = merge_bytes(cmp_shadow[63:32], req.wdata, req.wstrb);
        end
    endfunction

    task automatic do_txn(input logic write, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] wstrb);
        int region;
        tick();
        core_req_i = '{valid: 1'b1, write: write, addr: addr, wdata: wdata, wstrb: wstrb};
        forever begin
            @(negedge clk_i);
            if (core_ready_o) break;
        end
        // Accepted at the coming edge
        region = find_region(addr);
        exp_q.push_back(expect_rsp(core_req_i, time_o));
        acc_q.push_back(cyc);
        lat_q.push_back(region < 0 ? 1 : (region == TIMER_IDX ? 3 : 0));
        update_shadow(core_req_i);
        last_req = core_req_i;
        issued++;
        tick();
        core_req_i.valid = 1'b0;
        while (rsp_seen != issued) @(negedge clk_i);
    endtask

    always @(negedge clk_i) begin
        bus_rsp_t exp;
        int       acc;
        int       lat;
        if (rst_n_i && lat_q.size() > 0 && lat_q[0] == 1) begin
            check_value("mem_req_o.valid", mem_req_o.valid, 1'b0);
            check_value("uart_req_o.valid", uart_req_o.valid, 1'b0);
        end
        if (rst_n_i && core_rsp_o.valid) begin
            if (exp_q.size() == 0) begin
                $display("A response arrived with no access outstanding");
                $display("Simulation finished: FAIL");
                $fatal(1, "unexpected response");
            end
            exp = exp_q.pop_front();
            acc = acc_q.pop_front();
            lat = lat_q.pop_front();
            check_value("core_rsp_o.err", core_rsp_o.err, exp.err);
            check_value("core_rsp_o.rdata", core_rsp_o.rdata, exp.rdata);
            if (lat != 0) check_value("core_rsp_o latency", cyc - acc, lat);
            rsp_seen++;
        end
    end

    // Memory model with random ready and response delays
    always begin
        int          w;
        logic [31:0] rd;
        bus_req_t    req;
        tick();
        if (rst_n_i && mem_req_o.valid) begin
            w = $unsigned($random(seed)) % 4;
            repeat (w) tick();
            mem_ready_i = 1'b1;
            req = mem_req_o;
            check_value("mem_req_o.addr", req.addr, last_req.addr - REGION_BASE[MEM_IDX]);
            rd = mem_model.exists(req.addr) ? mem_model[req.addr] : '0;
            if (req.write) begin
                mem_model[req.addr] = merge_bytes(rd, req.wdata, req.wstrb);
                rd = '0;
            end
            tick();
            mem_ready_i = 1'b0;
            w = 1 + $unsigned($random(seed)) % 3;
            repeat (w - 1) tick();
            mem_rsp_i = '{valid: 1'b1, err: 1'b0, rdata: rd};
            tick();
            mem_rsp_i = '0;
        end
    end

    always begin
        int       w;
        bus_req_t req;
        tick();
        if (rst_n_i && uart_req_o.valid) begin
            w = $unsigned($random(seed)) % 3;
            repeat (w) tick();
            uart_ready_i = 1'b1;
            req = uart_req_o;
            check_value("uart_req_o.addr", req.addr, last_req.addr - REGION_BASE[UART_IDX]);
            check_value("uart_req_o.wdata", req.wdata, last_req.wdata);
            check_value("uart_req_o.wstrb", req.wstrb, last_req.wstrb);
            if (req.write) uart_log.push_back(req.wdata);
            tick();
            uart_ready_i = 1'b0;
            uart_rsp_i = '{valid: 1'b1, err: 1'b0, rdata: req.write ? '0 : UART_PATTERN};
            tick();
            uart_rsp_i = '0;
        end
    end

    initial begin
        repeat (NUM_TXN * 20 + 16) @(posedge clk_i);
        $display("Timeout: the test did not finish in time");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] r;
        logic [63:0] t;
        logic        saw_low;
        logic        saw_high;
        repeat (16) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        check_value("core_ready_o", core_ready_o, 1'b1);
        check_value("mem_req_o.valid", mem_req_o.valid, 1'b0);
        check_value("uart_req_o.valid", uart_req_o.valid, 1'b0);
        check_value("core_rsp_o.valid", core_rsp_o.valid, 1'b0);
        check_value("timer_irq_o", timer_irq_o, 1'b0);
        check_value("time_o", time_o, 64'd0);
        for (int i = 1; i < 6; i++) begin
            tick();
            check_value("time_o", time_o, 64'(i));
        end

        for (int i = 0; i < 60; i++) begin
            r = $random(seed);
            do_txn(r[0], REGION_BASE[MEM_IDX] + (32'(r[7:4]) << 2), $random(seed), r[11:8]);
        end

        for (int i = 0; i < 4; i++) begin
            do_txn(1'b1, REGION_BASE[UART_IDX] + 32'(i * 4), $random(seed), 4'hF - 4'(i));
            do_txn(1'b0, REGION_END[UART_IDX] - 32'd3 - 32'(i * 4), '0, '0);
        end
        check_value("UART write count", uart_log.size(), 4);

        do_txn(1'b0, 32'h0000_1000, '0, '0);
        do_txn(1'b1, 32'h4002_0000, 32'hDEAD_BEEF, 4'hF);
        do_txn(1'b0, 32'h4000_2000, '0, '0);
        do_txn(1'b1, 32'h9000_0000, 32'h1234_5678, 4'hF);

        do_txn(1'b1, REGION_BASE[TIMER_IDX] + TIMER_CMP_LO, 32'h1122_3344, 4'hF);
        do_txn(1'b1, REGION_BASE[TIMER_IDX] + TIMER_CMP_HI, 32'hAABB_CCDD, 4'b0101);
        do_txn(1'b0, REGION_BASE[TIMER_IDX] + TIMER_CMP_LO, '0, '0);
        do_txn(1'b0, REGION_BASE[TIMER_IDX] + TIMER_CMP_HI, '0, '0);
        do_txn(1'b1, REGION_BASE[TIMER_IDX] + TIMER_MTIME_LO, 32'h0, 4'hF);
        do_txn(1'b0, REGION_BASE[TIMER_IDX] + TIMER_MTIME_LO, '0, '0);
        do_txn(1'b0, REGION_BASE[TIMER_IDX] + TIMER_MTIME_HI, '0, '0);
        do_txn(1'b0, REGION_BASE[TIMER_IDX] + 32'h10, '0, '0);
        do_txn(1'b1, REGION_BASE[TIMER_IDX] + 32'h10, 32'h5555_5555, 4'hF);

        // Compare a little ahead of the counter
        do_txn(1'b1, REGION_BASE[TIMER_IDX] + TIMER_CMP_HI, 32'h0, 4'hF);
        t = time_o + 64'd30;
        do_txn(1'b1, REGION_BASE[TIMER_IDX] + TIMER_CMP_LO, t[31:0], 4'hF);
        saw_low  = 1'b0;
        saw_high = 1'b0;
        repeat (60) begin
            @(negedge clk_i);
            check_value("timer_irq_o", timer_irq_o, time_o >= cmp_shadow);
            if (timer_irq_o) saw_high = 1'b1;
            else saw_low = 1'b1;
        end
        check_value("irq low phase seen", saw_low, 1'b1);
        check_value("irq high phase seen", saw_high, 1'b1);
        do_txn(1'b1, REGION_BASE[TIMER_IDX] + TIMER_CMP_HI, 32'h1, 4'hF);
        @(negedge clk_i);
        check_value("timer_irq_o", timer_irq_o, 1'b0);

        repeat (4) @(posedge clk_i);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* compile.f */
verilog/fabric_pkg.sv
verilog/addr_decoder.sv
verilog/region_slice.sv
verilog/resp_merger.sv
verilog/mtimer.sv
verilog/periph_fabric.sv
dv/periph_fabric_sva.sv
dv/periph_fabric_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module periph_fabric_tb \
    -f compile.f -o periph_fabric_sim > build.log 2>&1 \
    && ./obj_dir/periph_fabric_sim > sim.log 2>&1
cat sim.log 2>/dev/null || cat build.log
grep -q "Simulation finished: PASS" sim.log && echo "run.sh: passed" && exit 0 \
    || { echo "run.sh: failed"; exit 1; }
